// ==== led_pkg.sv ====
// Shared widths, register map, encoder timing, enums and structs
// for the serial RGB LED string controller

package led_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int PIX_AW      = 10;  // 1024 pixel bytes
  localparam int PIX_DW      = 8;
  localparam int APB_AW      = 13;
  localparam int APB_DW      = 32;
  localparam int REP_W       = 4;
  localparam int PRE_W       = 16;
  localparam int CELL_W      = 5;   // Holds 0 .. T_CELL-1
  localparam int MEM_SEL_BIT = 12;  // Memory window select in paddr

  // Bit cell timing, in ticks
  localparam int T_ZERO = 8;
  localparam int T_ONE  = 16;
  localparam int T_CELL = 24;

  ////////////////////////////////////////////////////////////
  // Register fields
  ////////////////////////////////////////////////////////////
  localparam int CFG_EN_BIT     = 0;
  localparam int CFG_IRQ_EN_BIT = 1;
  localparam int CFG_POL_BIT    = 2;

  localparam int CTRL_START_BIT = 31;
  localparam int CTRL_PROG_BIT  = 29;
  localparam int CTRL_REP_LSB   = 25;  // Bits 28:25
  localparam int CTRL_LAST_LSB  = 12;  // Bits 22:12, top bit reads 0
  localparam int CTRL_FIRST_LSB = 0;   // Bits 9:0

  typedef enum logic [APB_AW-1:0] {
    CONFIG   = 13'h000,
    PRESCALE = 13'h004,
    CTRL     = 13'h008
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    RAM_REQ,
    RAM_WAIT,
    SHIFT
  } seq_state_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
  } apb_rsp_t;

  typedef struct packed {
    logic [REP_W-1:0]  rep_cnt;   // Extra passes over the range
    logic [PIX_AW-1:0] first_idx;
    logic [PIX_AW-1:0] last_idx;
  } seq_cfg_t;

  typedef struct packed {
    logic              we;
    logic [PIX_AW-1:0] addr;
    logic [PIX_DW-1:0] data;
  } ram_wr_t;

  typedef struct packed {
    logic valid;
    logic value;
  } led_bit_t;

endpackage

// ==== led_pixel_ram.sv ====
// Pixel byte memory
// One write port from the register block, one registered read port

module led_pixel_ram (
  input  logic                         clk,
  input  led_pkg::ram_wr_t             wr_i,
  input  logic [led_pkg::PIX_AW-1:0]   rd_addr_i,
  output logic [led_pkg::PIX_DW-1:0]   rd_data_o
);

  localparam int DEPTH = 2 ** led_pkg::PIX_AW;

  // Plain array, inferred as block RAM
  logic [led_pkg::PIX_DW-1:0] mem [0:DEPTH-1];

  // Host write port
  always_ff @(posedge clk) begin
    if (wr_i.we) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  // Sequencer read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// ==== led_apb_regs.sv ====
// APB register block: CONFIG, PRESCALE and CTRL registers,
// pixel memory write window, start pulse and end-of-frame interrupt

module led_apb_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  led_pkg::apb_req_t            apb_i,
  output led_pkg::apb_rsp_t            apb_o,
  output logic                         en_o,
  output logic                         pol_o,
  output logic [led_pkg::PRE_W-1:0]    prescale_o,
  output led_pkg::seq_cfg_t            cfg_o,
  output logic                         start_o,
  input  logic                         progress_i,
  output led_pkg::ram_wr_t             ram_wr_o,
  output logic                         irq_o
);

  logic mem_sel;
  logic wr_acc;
  logic wr_reg;
  logic rd_reg;
  logic irq_en;
  logic progress_q;
  logic [led_pkg::APB_DW-1:0] rd_data;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////
  assign mem_sel = apb_i.paddr[led_pkg::MEM_SEL_BIT];
  assign wr_acc  = apb_i.psel && apb_i.penable && apb_i.pwrite;
  assign wr_reg  = wr_acc && !mem_sel;
  assign rd_reg  = apb_i.psel && !apb_i.pwrite && !mem_sel;  // Window reads give 0

  // No wait states
  assign apb_o.pready = 1'b1;
  assign apb_o.prdata = rd_data;

  // Memory write lands on the edge that ends the access cycle
  assign ram_wr_o.we   = wr_acc && mem_sel;
  assign ram_wr_o.addr = apb_i.paddr[2 +: led_pkg::PIX_AW];
  assign ram_wr_o.data = apb_i.pwdata[led_pkg::PIX_DW-1:0];

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_o       <= 1'b0;
      irq_en     <= 1'b0;
      pol_o      <= 1'b0;
      prescale_o <= '0;
      cfg_o      <= '0;
    end else if (wr_reg) begin
      case (apb_i.paddr)
        led_pkg::CONFIG: begin
          en_o   <= apb_i.pwdata[led_pkg::CFG_EN_BIT];
          irq_en <= apb_i.pwdata[led_pkg::CFG_IRQ_EN_BIT];
          pol_o  <= apb_i.pwdata[led_pkg::CFG_POL_BIT];
        end
        led_pkg::PRESCALE: begin
          prescale_o <= apb_i.pwdata[led_pkg::PRE_W-1:0];
        end
        led_pkg::CTRL: begin
          cfg_o.rep_cnt   <= apb_i.pwdata[led_pkg::CTRL_REP_LSB +: led_pkg::REP_W];
          cfg_o.last_idx  <= apb_i.pwdata[led_pkg::CTRL_LAST_LSB +: led_pkg::PIX_AW];
          cfg_o.first_idx <= apb_i.pwdata[led_pkg::CTRL_FIRST_LSB +: led_pkg::PIX_AW];
        end
        default: ;
      endcase
    end
  end

  // Start is a strobe, it never holds in the register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_o <= 1'b0;
    end else begin
      start_o <= wr_reg && (apb_i.paddr == led_pkg::CTRL) &&
                 apb_i.pwdata[led_pkg::CTRL_START_BIT];
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    if (rd_reg) begin
      case (apb_i.paddr)
        led_pkg::CONFIG: begin
          rd_data[led_pkg::CFG_EN_BIT]     = en_o;
          rd_data[led_pkg::CFG_IRQ_EN_BIT] = irq_en;
          rd_data[led_pkg::CFG_POL_BIT]    = pol_o;
        end
        led_pkg::PRESCALE: begin
          rd_data[led_pkg::PRE_W-1:0] = prescale_o;
        end
        led_pkg::CTRL: begin
          rd_data[led_pkg::CTRL_PROG_BIT] = progress_i;
          rd_data[led_pkg::CTRL_REP_LSB +: led_pkg::REP_W]    = cfg_o.rep_cnt;
          rd_data[led_pkg::CTRL_LAST_LSB +: led_pkg::PIX_AW]  = cfg_o.last_idx;
          rd_data[led_pkg::CTRL_FIRST_LSB +: led_pkg::PIX_AW] = cfg_o.first_idx;
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////////////////////////
  // Falling edge of progress ends a frame. A frame cut short by
  // clearing enable raises nothing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      progress_q <= 1'b0;
      irq_o      <= 1'b0;
    end else begin
      progress_q <= progress_i;
      irq_o      <= irq_en && en_o && progress_q && !progress_i;
    end
  end

endmodule

// ==== led_frame_seq.sv ====
// Frame sequencer: walks pixel bytes first..last, repeat+1 times,
// and hands their bits MSB first to the bit encoder

module led_frame_seq (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         en_i,
  input  led_pkg::seq_cfg_t            cfg_i,
  input  logic                         start_i,
  output logic                         progress_o,
  output logic [led_pkg::PIX_AW-1:0]   rd_addr_o,
  input  logic [led_pkg::PIX_DW-1:0]   rd_data_i,
  output led_pkg::led_bit_t            bit_o,
  input  logic                         ready_i
);

  localparam int BCNT_W = $clog2(led_pkg::PIX_DW);

  led_pkg::seq_state_e         state;
  logic [led_pkg::PIX_AW-1:0]  idx;       // Current byte
  logic [led_pkg::PIX_AW-1:0]  first_idx;
  logic [led_pkg::PIX_AW-1:0]  last_idx;
  logic [led_pkg::REP_W-1:0]   rep;       // Passes still to go
  logic [led_pkg::PIX_DW-1:0]  shift_q;
  logic [BCNT_W-1:0]           bit_cnt;   // Bits left after the current one

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !en_i) begin
      state   <= led_pkg::IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        led_pkg::IDLE: begin
          if (start_i) begin
            state <= led_pkg::RAM_REQ;
          end
        end
        led_pkg::RAM_REQ: begin
          state <= led_pkg::RAM_WAIT;  // Address goes out this cycle
        end
        led_pkg::RAM_WAIT: begin
          bit_cnt <= BCNT_W'(led_pkg::PIX_DW - 1);
          state   <= led_pkg::SHIFT;
        end
        led_pkg::SHIFT: begin
          if (ready_i) begin
            if (bit_cnt != '0) begin
              bit_cnt <= bit_cnt - 1'b1;
            end else if (idx != last_idx || rep != '0) begin
              state <= led_pkg::RAM_REQ;
            end else begin
              state <= led_pkg::IDLE;  // Frame done
            end
          end
        end
        default: state <= led_pkg::IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Index, repeat and shift byte
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    case (state)
      led_pkg::IDLE: begin
        if (start_i) begin
          idx       <= cfg_i.first_idx;
          first_idx <= cfg_i.first_idx;
          last_idx  <= cfg_i.last_idx;
          rep       <= cfg_i.rep_cnt;
        end
      end
      led_pkg::RAM_WAIT: shift_q <= rd_data_i;  // RAM data valid now
      led_pkg::SHIFT: begin
        if (ready_i) begin
          shift_q <= {shift_q[led_pkg::PIX_DW-2:0], 1'b0};
          if (bit_cnt == '0) begin
            if (idx != last_idx) begin
              idx <= idx + 1'b1;
            end else begin
              idx <= first_idx;     // Next pass
              rep <= rep - 1'b1;
            end
          end
        end
      end
      default: ;
    endcase
  end

  assign rd_addr_o   = idx;
  assign progress_o  = (state != led_pkg::IDLE);
  assign bit_o.valid = (state == led_pkg::SHIFT);
  assign bit_o.value = (state == led_pkg::SHIFT) && shift_q[led_pkg::PIX_DW-1];

endmodule

// ==== led_bit_encoder.sv ====
// Tick prescaler and pulse-width bit encoder
// Each bit is a cell of T_CELL ticks, active for T_ZERO or T_ONE ticks

module led_bit_encoder (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        en_i,
  input  logic [led_pkg::PRE_W-1:0]   prescale_i,
  input  logic                        pol_i,
  input  led_pkg::led_bit_t           bit_i,
  output logic                        ready_o,
  output logic                        sout_o
);

  localparam logic [led_pkg::CELL_W-1:0] CELL_END = led_pkg::CELL_W'(led_pkg::T_CELL - 1);
  localparam logic [led_pkg::CELL_W-1:0] LEN_ZERO = led_pkg::CELL_W'(led_pkg::T_ZERO);
  localparam logic [led_pkg::CELL_W-1:0] LEN_ONE  = led_pkg::CELL_W'(led_pkg::T_ONE);

  logic [led_pkg::PRE_W-1:0]  pre_cnt;
  logic                       tick;
  logic [led_pkg::CELL_W-1:0] cell_cnt;  // Parks at CELL_END when idle
  logic                       dbit;
  logic                       polar;
  logic [led_pkg::CELL_W-1:0] act_len;

  // >= keeps the count sane if prescale shrinks mid-count
  assign tick    = (pre_cnt >= prescale_i);
  assign act_len = dbit ? LEN_ONE : LEN_ZERO;

  ////////////////////////////////////////////////////////////
  // Prescaler and cell counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pre_cnt  <= '0;
      cell_cnt <= CELL_END;
      ready_o  <= 1'b0;
      dbit     <= 1'b0;
      polar    <= 1'b0;
      sout_o   <= 1'b0;
    end else if (!en_i) begin
      pre_cnt  <= '0;
      cell_cnt <= CELL_END;
      ready_o  <= 1'b0;
      polar    <= pol_i;
      sout_o   <= pol_i;                      // Back to idle level
    end else begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      ready_o <= tick && (cell_cnt == CELL_END) && bit_i.valid;
      if (cell_cnt == CELL_END) begin
        polar <= pol_i;                       // Idle level follows config
      end
      if (tick) begin
        if (cell_cnt != CELL_END) begin
          cell_cnt <= cell_cnt + 1'b1;
        end else if (bit_i.valid) begin
          cell_cnt <= '0;                     // New cell
          dbit     <= bit_i.value;
        end
      end
      // Active level is the inverse of polarity
      sout_o <= (cell_cnt < act_len) ? ~polar : polar;
    end
  end

endmodule

// ==== string_led_ctrl.sv ====
// Top level of the LED string controller
// APB registers, pixel memory, frame sequencer and bit encoder

module string_led_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  led_pkg::apb_req_t  apb_i,
  output led_pkg::apb_rsp_t  apb_o,
  output logic               irq_o,
  output logic               sout_o
);

  logic                       en;
  logic                       pol;
  logic [led_pkg::PRE_W-1:0]  prescale;
  led_pkg::seq_cfg_t          cfg;
  logic                       start;
  logic                       progress;
  led_pkg::ram_wr_t           ram_wr;
  logic [led_pkg::PIX_AW-1:0] rd_addr;
  logic [led_pkg::PIX_DW-1:0] rd_data;
  led_pkg::led_bit_t          led_bit;
  logic                       ready;

  led_apb_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_i      (apb_i),
    .apb_o      (apb_o),
    .en_o       (en),
    .pol_o      (pol),
    .prescale_o (prescale),
    .cfg_o      (cfg),
    .start_o    (start),
    .progress_i (progress),
    .ram_wr_o   (ram_wr),
    .irq_o      (irq_o)
  );

  led_pixel_ram u_ram (
    .clk       (clk),
    .wr_i      (ram_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  led_frame_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (en),
    .cfg_i      (cfg),
    .start_i    (start),
    .progress_o (progress),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data),
    .bit_o      (led_bit),
    .ready_i    (ready)
  );

  led_bit_encoder u_enc (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (en),
    .prescale_i (prescale),
    .pol_i      (pol),
    .bit_i      (led_bit),
    .ready_o    (ready),
    .sout_o     (sout_o)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock, 8 ns period, and the reset source

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS    = 4;
  localparam int RST_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== string_led_assert.sv ====
// Concurrent checks on the frame sequencer handshake and FSM
// bound into every led_frame_seq instance

module string_led_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       en_i,
  input logic                       start_i,
  input logic                       progress_i,
  input led_pkg::led_bit_t          bit_i,
  input logic                       ready_i,
  input led_pkg::seq_state_e        state_i,
  input logic [led_pkg::PIX_AW-1:0] first_i,
  input logic [led_pkg::PIX_AW-1:0] last_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Offered bit holds until the encoder takes it
  valid_hold: assert property (@(posedge clk) disable iff (!rst_n || !en_i)
    bit_i.valid && !ready_i |=> bit_i.valid && $stable(bit_i.value))
    else $error("bit offer dropped or changed before ready");

  // Progress rises one clock after a start in IDLE
  start_progress: assert property (@(posedge clk) disable iff (!rst_n || !en_i)
    start_i && state_i == led_pkg::IDLE |=> progress_i)
    else $error("progress did not rise after a start");

  ready_with_valid: assert property (@(posedge clk) disable iff (!rst_n || !en_i)
    ready_i |-> bit_i.valid)
    else $error("ready without a bit on offer");

  // Busy start must not reload the range
  busy_start: assert property (@(posedge clk) disable iff (!rst_n || !en_i)
    start_i && state_i != led_pkg::IDLE |=> $stable(first_i) && $stable(last_i))
    else $error("start while busy disturbed the running frame");

endmodule

bind led_frame_seq string_led_assert u_seq_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .en_i       (en_i),
  .start_i    (start_i),
  .progress_i (progress_o),
  .bit_i      (bit_o),
  .ready_i    (ready_i),
  .state_i    (state),
  .first_i    (first_idx),
  .last_i     (last_idx)
);

// ==== tb_string_led.sv ====
// LED string controller testbench with pattern reader, APB driver,
// serial line decoder, checks and watchdog

module tb_string_led;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_NS    = 8;
  localparam int          RECORD_NS = 200;   // Allowance per pattern record
  localparam int          MARGIN_NS = 4000;
  localparam logic [12:0] MEM_BASE  = 13'h1000;

  logic              clk;
  logic              rst_n;
  led_pkg::apb_req_t apb_req;
  led_pkg::apb_rsp_t apb_rsp;
  logic              irq;
  logic              sout;

  logic [7:0]  mirror [0:1023];  // Host copy of the pixel memory
  logic        cfg_irq_en = 1'b0;
  logic        cfg_pol = 1'b0;
  logic [15:0] cfg_pre = '0;
  logic        got_bits [$];
  logic        exp_bits [$];
  int          act_clks = 0;
  int          irq_count = 0;
  int          errors = 0;
  int          seed = 32'h576a;
  longint      deadline_ns = MARGIN_NS;

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  string_led_ctrl UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .apb_i  (apb_req),
    .apb_o  (apb_rsp),
    .irq_o  (irq),
    .sout_o (sout)
  );

  ////////////////////////////////////////////////////////////
  // Serial decoder and interrupt counter
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (sout != cfg_pol) begin
      act_clks = act_clks + 1;
    end else if (act_clks != 0) begin
      // Long pulse is a 1 bit
      got_bits.push_back(act_clks > (led_pkg::T_ZERO + led_pkg::T_ONE) / 2 * (int'(cfg_pre) + 1));
      act_clks = 0;
    end
    if (irq) irq_count = irq_count + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [12:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready) @(posedge clk);
    rdata = apb_rsp.prdata;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [12:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    apb_access(1'b1, addr, data, rd);
    if (addr[led_pkg::MEM_SEL_BIT]) begin
      mirror[addr[11:2]] = data[7:0];
    end else if (addr == led_pkg::CONFIG) begin
      cfg_irq_en = data[led_pkg::CFG_IRQ_EN_BIT];
      cfg_pol    = data[led_pkg::CFG_POL_BIT];
    end else if (addr == led_pkg::PRESCALE) begin
      cfg_pre = data[15:0];
    end
  endtask

  task automatic random_fill(input logic [9:0] first, input int count);
    logic [9:0] idx;
    idx = first;
    deadline_ns = deadline_ns + longint'(count) * 4 * CLK_NS;
    for (int i = 0; i < count; i++) begin
      write_reg(MEM_BASE | {1'b0, idx, 2'b00}, $random(seed));
      idx = idx + 1'b1;
    end
  endtask

  // Expected bits of bytes first to last MSB first over repeat+1 passes
  task automatic expected_stream(input logic [31:0] ctrl);
    logic [9:0] idx;
    exp_bits.delete();
    for (int pass = 0; pass <= ctrl[28:25]; pass++) begin
      idx = ctrl[9:0];
      for (int n = 0; n < 1024; n++) begin
        for (int b = 7; b >= 0; b--) exp_bits.push_back(mirror[idx][b]);
        if (idx == ctrl[21:12]) break;
        idx = idx + 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Frame playback that stops early when stop_after is non-zero
  ////////////////////////////////////////////////////////////
  task automatic run_frame(input logic [31:0] ctrl, input int stop_after);
    logic [31:0] rd;
    int          cell_clks;
    int          n_bits;
    expected_stream(ctrl);
    n_bits    = (stop_after > 0) ? stop_after : exp_bits.size();
    cell_clks = led_pkg::T_CELL * (int'(cfg_pre) + 1);
    deadline_ns = deadline_ns + longint'(n_bits + 3) * cell_clks * CLK_NS + MARGIN_NS;
    write_reg(led_pkg::CTRL, ctrl | 32'h8000_0000);
    got_bits.delete();  // Drop idle level changes seen before the start
    irq_count = 0;
    apb_access(1'b0, led_pkg::CTRL, '0, rd);
    check_value("progress while playing", rd[led_pkg::CTRL_PROG_BIT], 1'b1);
    if (stop_after > 0) begin
      while (got_bits.size() < stop_after) @(negedge clk);
      write_reg(led_pkg::CONFIG, {29'd0, cfg_pol, cfg_irq_en, 1'b0});
    end else begin
      // Start with another range while busy, then put CTRL back
      write_reg(led_pkg::CTRL, (ctrl ^ 32'h0000_1001) | 32'h8000_0000);
      write_reg(led_pkg::CTRL, ctrl);
      while (rd[led_pkg::CTRL_PROG_BIT]) apb_access(1'b0, led_pkg::CTRL, '0, rd);
      while (got_bits.size() < n_bits) @(negedge clk);
    end
    repeat (2 * cell_clks) @(negedge clk);  // Line stays quiet afterwards
    check_value("bit count", got_bits.size(), n_bits);
    for (int i = 0; i < n_bits; i++) begin
      check_value($sformatf("stream bit %0d", i), got_bits[i], exp_bits[i]);
    end
    check_value("sout at rest", sout, cfg_pol);
    check_value("irq pulses", irq_count, (cfg_irq_en && stop_after == 0) ? 1 : 0);
    apb_access(1'b0, led_pkg::CTRL, '0, rd);
    check_value("progress after frame", rd[led_pkg::CTRL_PROG_BIT], 1'b0);
  endtask

  initial begin : watchdog
    while ($time <= deadline_ns) @(negedge clk);
    abort_run($sformatf("Timeout: the run did not finish within %0d ns", deadline_ns));
  end

  initial begin : main
    int          fd;
    int          n;
    int          k;
    byte         op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] rd;
    string       line;
    apb_req = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("pready after reset", apb_rsp.pready, 1'b1);
    check_value("sout after reset", sout, 1'b0);
    check_value("irq after reset", irq, 1'b0);
    fd = $fopen("led_patterns.txt", "r");
    if (fd == 0) abort_run("Cannot open the pattern file led_patterns.txt");
    n = $fscanf(fd, " %c", op);
    while (n == 1) begin
      deadline_ns = deadline_ns + RECORD_NS;
      case (op)
        "#": n = $fgets(line, fd);
        "W": begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) abort_run("Short write record in the pattern file");
          write_reg(a[12:0], d);
        end
        "R": begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) abort_run("Short read record in the pattern file");
          apb_access(1'b0, a[12:0], '0, rd);
          check_value($sformatf("read of %h", a[12:0]), rd, d);
        end
        "M": begin
          n = $fscanf(fd, "%h %h", a, d);
          if (n != 2) abort_run("Short memory fill record in the pattern file");
          random_fill(a[9:0], d);
        end
        "F": begin
          n = $fscanf(fd, "%h", d);
          if (n != 1) abort_run("Short frame record in the pattern file");
          run_frame(d, 0);
        end
        "S": begin
          n = $fscanf(fd, "%h %d", d, k);
          if (n != 2) abort_run("Short stop record in the pattern file");
          run_frame(d, k);
        end
        default: abort_run($sformatf("Unknown record '%c' in the pattern file", op));
      endcase
      n = $fscanf(fd, " %c", op);
    end
    $fclose(fd);
    if (errors == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("Mismatches were found");
    end
  end

endmodule

// ==== led_patterns.txt ====
# W addr data | R addr expected | M first_index count   (all hex)
# F ctrl | S ctrl bits_before_enable_clear   (ctrl hex, bits decimal)
# register read-back, enable still off
R 0000 00000000
W 0008 8ABC51A7
R 0008 0A3C51A7
W 0004 ABCD1234
R 0004 00001234
W 0000 000000FE
R 0000 00000006
# single frame, irq on, prescale 0
W 0004 00000000
W 0000 00000003
W 1000 000000A5
W 1004 0000003C
W 1008 000000FF
W 100C 00000000
F 00003000
R 0008 00003000
# repeat, eight random bytes played three times
M 010 020
F 04017010
# inverted line, prescale 3, irq off
W 0000 00000005
W 0004 00000003
F 0001B014
# enable cleared mid-frame, then a full frame
W 0000 00000003
W 0004 00000002
M 300 010
S 0230F300 20
W 0000 00000003
F 0230F300

// ==== project.f ====
led_pkg.sv
led_pixel_ram.sv
led_apb_regs.sv
led_frame_seq.sv
led_bit_encoder.sv
string_led_ctrl.sv
tb_clock_gen.sv
string_led_assert.sv
tb_string_led.sv
